// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build portalBridgeTb with Verilator and run it"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module portalBridgeTb -f all.f -o simv
	./obj_dir/simv | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
verilog/portalPkg.sv
verilog/syncFifo.sv
verilog/beatIf.sv
verilog/portalQueueIf.sv
verilog/burstSplitter.sv
verilog/portalReadEngine.sv
verilog/portalWriteEngine.sv
verilog/portalQueues.sv
verilog/portalBridge.sv
verification/portalBridgeTb.sv

// File: verification/portalBridgeTb.sv
`timescale 1ns/1ps

module portalBridgeTb;

  localparam int idWidth          = 6;
  localparam int queueDepth       = 4;
  localparam int timeoutCycles    = 200;
  localparam logic reqP           = 1'b1;  // Address bit 12 set
  localparam logic indP           = 1'b0;
  localparam logic [6:0] ctrlPage = 7'd0;
  localparam logic [6:0] dataPage = 7'd1;

  typedef enum logic [1:0] {opRead, opWrite, opPushInd, opHoldAck} opT;

  typedef struct packed {
    opT               kind;
    logic             portal;
    logic [6:0]       page;
    logic [4:0]       offset;
    logic [3:0]       len;
    logic [5:0]       id;
    logic [31:0]      data;  // First write word, indication word or hold flag
    logic             irq;   // Interrupt level after the step
    logic [4:0][31:0] exp;   // Read data per beat
  } stepT;

  logic                 CLK;
  logic                 RST_N;
  logic [31:0]          arAddr;
  logic [3:0]           arLen;
  logic [idWidth-1:0]   arId;
  logic                 arValid;
  logic                 arReady;
  logic [31:0]          rData;
  logic [idWidth-1:0]   rId;
  logic                 rValid;
  logic                 rReady;
  logic [31:0]          awAddr;
  logic [3:0]           awLen;
  logic [idWidth-1:0]   awId;
  logic                 awValid;
  logic                 awReady;
  logic [31:0]          wData;
  logic                 wValid;
  logic                 wReady;
  logic [idWidth-1:0]   bId;
  logic                 bValid;
  logic                 bReady;
  logic                 interrupt;
  logic [31:0]          reqWord;
  logic                 reqReq;
  logic                 reqAck;
  logic [31:0]          indWord;
  logic                 indReq;
  logic                 indAck;

  stepT        steps[$];
  logic [31:0] reqSeen[$];
  logic [31:0] reqExpected[$];
  int          seed = 32'h13be;
  int          checkCount = 0;
  int          errorCount = 0;
  int          timeoutCount = 0;
  bit          timedOut = 1'b0;
  bit          ackHold = 1'b0;

  portalBridge #(.idWidth(idWidth), .queueDepth(queueDepth)) dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    timeoutCount++;
    timedOut = 1'b1;
  endtask

  function automatic bit randomBit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic logic [31:0] makeAddr(input stepT s);
    return {19'd0, s.portal, s.page, s.offset};
  endfunction

  task automatic addStep(input opT kind, input logic portal, input logic [6:0] page,
                         input logic [4:0] offset, input logic [3:0] len,
                         input logic [5:0] id, input logic [31:0] data, input logic irq,
                         input logic [31:0] e0, input logic [31:0] e1,
                         input logic [31:0] e2, input logic [31:0] e3,
                         input logic [31:0] e4);
    stepT s;
    s.kind   = kind;
    s.portal = portal;
    s.page   = page;
    s.offset = offset;
    s.len    = len;
    s.id     = id;
    s.data   = data;
    s.irq    = irq;
    s.exp[0] = e0;
    s.exp[1] = e1;
    s.exp[2] = e2;
    s.exp[3] = e3;
    s.exp[4] = e4;
    steps.push_back(s);
  endtask

  task automatic buildTable();
    // Control map on both portals, 24..28 then wrap to 0
    addStep(opRead, indP, ctrlPage, 5'd4, 4'd4, 6'd1, 32'd0, 1'b0,
            32'h005A05A0, 32'd1, 32'd0, 32'd5, 32'd2);
    addStep(opRead, indP, ctrlPage, 5'd24, 4'd2, 6'd2, 32'd0, 1'b0,
            32'h005A05A0, 32'h005A05A0, 32'd0, 32'd0, 32'd0);
    addStep(opRead, reqP, ctrlPage, 5'd4, 4'd4, 6'd3, 32'd0, 1'b0,
            32'h005A05A0, 32'd1, 32'd0, 32'd6, 32'd2);
    addStep(opRead, reqP, ctrlPage, 5'd24, 4'd0, 6'd4, 32'd0, 1'b0,
            32'h005A05A0, 32'd0, 32'd0, 32'd0, 32'd0);
    addStep(opWrite, reqP, dataPage, 5'd0, 4'd3, 6'd9, 32'h1000, 1'b0, 0, 0, 0, 0, 0);
    addStep(opPushInd, indP, ctrlPage, 5'd0, 4'd0, 6'd0, 32'hA1, 1'b0, 0, 0, 0, 0, 0);
    addStep(opPushInd, indP, ctrlPage, 5'd0, 4'd0, 6'd0, 32'hB2, 1'b0, 0, 0, 0, 0, 0);
    addStep(opPushInd, indP, ctrlPage, 5'd0, 4'd0, 6'd0, 32'hC3, 1'b0, 0, 0, 0, 0, 0);
    addStep(opRead, indP, ctrlPage, 5'd0, 4'd0, 6'd5, 32'd0, 1'b0, 32'd1, 0, 0, 0, 0);
    addStep(opRead, indP, ctrlPage, 5'd12, 4'd0, 6'd6, 32'd0, 1'b0, 32'd1, 0, 0, 0, 0);
    addStep(opWrite, indP, ctrlPage, 5'd4, 4'd0, 6'd7, 32'd1, 1'b1, 0, 0, 0, 0, 0);
    addStep(opRead, indP, dataPage, 5'd0, 4'd0, 6'd8, 32'd0, 1'b1, 32'hA1, 0, 0, 0, 0);
    addStep(opRead, indP, dataPage, 5'd0, 4'd0, 6'd8, 32'd0, 1'b1, 32'hB2, 0, 0, 0, 0);
    addStep(opRead, indP, dataPage, 5'd0, 4'd0, 6'd8, 32'd0, 1'b0, 32'hC3, 0, 0, 0, 0);
    addStep(opRead, indP, ctrlPage, 5'd0, 4'd0, 6'd5, 32'd0, 1'b0, 32'd0, 0, 0, 0, 0);
    // Request space probe with ack withheld
    addStep(opHoldAck, reqP, ctrlPage, 5'd0, 4'd0, 6'd0, 32'd1, 1'b0, 0, 0, 0, 0, 0);
    addStep(opWrite, reqP, dataPage, 5'd0, 4'd1, 6'd10, 32'h2000, 1'b0, 0, 0, 0, 0, 0);
    addStep(opRead, reqP, dataPage, 5'd4, 4'd0, 6'd11, 32'd0, 1'b0, 32'd1, 0, 0, 0, 0);
    addStep(opWrite, reqP, dataPage, 5'd0, 4'd2, 6'd12, 32'h3000, 1'b0, 0, 0, 0, 0, 0);
    addStep(opRead, reqP, dataPage, 5'd4, 4'd0, 6'd13, 32'd0, 1'b0, 32'd0, 0, 0, 0, 0);
    addStep(opHoldAck, reqP, ctrlPage, 5'd0, 4'd0, 6'd0, 32'd0, 1'b0, 0, 0, 0, 0, 0);
    addStep(opRead, indP, ctrlPage, 5'd8, 4'd2, 6'd14, 32'd0, 1'b0,
            32'd1, 32'd0, 32'd5, 32'd0, 32'd0);
    // Discarded writes, one response each
    addStep(opWrite, indP, dataPage, 5'd0, 4'd1, 6'd20, 32'h4000, 1'b0, 0, 0, 0, 0, 0);
    addStep(opWrite, indP, dataPage, 5'd8, 4'd0, 6'd21, 32'h5000, 1'b0, 0, 0, 0, 0, 0);
    addStep(opWrite, reqP, ctrlPage, 5'd24, 4'd2, 6'd22, 32'h6000, 1'b0, 0, 0, 0, 0, 0);
  endtask

  task automatic readBurst(input stepT s);
    int waitCycles;
    int beatNum;
    bit accepted;
    arAddr  <= makeAddr(s);
    arLen   <= s.len;
    arId    <= s.id;
    arValid <= 1'b1;
    waitCycles = 0;
    accepted = 1'b0;
    while (!accepted && !timedOut) begin
      @(posedge CLK);
      if (arReady) begin
        accepted = 1'b1;
      end else begin
        waitCycles++;
        if (waitCycles > timeoutCycles) begin
          reportTimeout("arReady");
        end
      end
    end
    arValid <= 1'b0;
    beatNum = 0;
    waitCycles = 0;
    rReady <= randomBit();
    while (beatNum <= int'(s.len) && !timedOut) begin
      @(posedge CLK);
      if (rValid && rReady) begin
        checkValue("rData", rData, s.exp[beatNum]);
        checkValue("rId", 32'(rId), 32'(s.id));
        beatNum++;
        waitCycles = 0;
      end else begin
        waitCycles++;
        if (waitCycles > timeoutCycles) begin
          reportTimeout("read data beat");
        end
      end
      rReady <= (beatNum <= int'(s.len)) ? randomBit() : 1'b0;
    end
  endtask

  task automatic sendWriteAddr(input logic [31:0] addr, input logic [3:0] len,
                               input logic [5:0] id);
    int waitCycles;
    bit accepted;
    awAddr  <= addr;
    awLen   <= len;
    awId    <= id;
    awValid <= 1'b1;
    waitCycles = 0;
    accepted = 1'b0;
    while (!accepted && !timedOut) begin
      @(posedge CLK);
      if (awReady) begin
        accepted = 1'b1;
      end else begin
        waitCycles++;
        if (waitCycles > timeoutCycles) begin
          reportTimeout("awReady");
        end
      end
    end
    awValid <= 1'b0;
  endtask

  task automatic sendWriteData(input logic [31:0] first, input logic [3:0] len);
    int waitCycles;
    bit accepted;
    for (int i = 0; i <= int'(len) && !timedOut; i++) begin
      wData  <= first + i;
      wValid <= 1'b1;
      waitCycles = 0;
      accepted = 1'b0;
      while (!accepted && !timedOut) begin
        @(posedge CLK);
        if (wReady) begin
          accepted = 1'b1;
        end else begin
          waitCycles++;
          if (waitCycles > timeoutCycles) begin
            reportTimeout("wReady");
          end
        end
      end
    end
    wValid <= 1'b0;
  endtask

  task automatic writeBurst(input stepT s);
    int waitCycles;
    bit done;
    if (s.portal == reqP && s.page != ctrlPage) begin
      for (int i = 0; i <= int'(s.len); i++) begin
        reqExpected.push_back(s.data + i);
      end
    end
    fork
      sendWriteAddr(makeAddr(s), s.len, s.id);
      sendWriteData(s.data, s.len);
    join
    bReady <= randomBit();
    waitCycles = 0;
    done = 1'b0;
    while (!done && !timedOut) begin
      @(posedge CLK);
      if (bValid && bReady) begin
        checkValue("bId", 32'(bId), 32'(s.id));
        done = 1'b1;
      end else begin
        waitCycles++;
        if (waitCycles > timeoutCycles) begin
          reportTimeout("write response");
        end
      end
      bReady <= done ? 1'b0 : randomBit();
    end
    if (done) begin
      @(posedge CLK);
      checkValue("bValid", 32'(bValid), 32'd0);  // Single response per burst
    end
  endtask

  task automatic pushIndication(input logic [31:0] word);
    int waitCycles;
    indWord <= word;
    indReq  <= 1'b1;
    waitCycles = 0;
    while (!indAck && !timedOut) begin
      @(posedge CLK);
      waitCycles++;
      if (!indAck && waitCycles > timeoutCycles) begin
        reportTimeout("indAck high");
      end
    end
    indReq <= 1'b0;
    waitCycles = 0;
    while (indAck && !timedOut) begin
      @(posedge CLK);
      waitCycles++;
      if (indAck && waitCycles > timeoutCycles) begin
        reportTimeout("indAck low");
      end
    end
  endtask

  task automatic waitRequestsDrained(input string what);
    int waitCycles;
    waitCycles = 0;
    while (!timedOut && (reqSeen.size() < reqExpected.size() || reqReq || reqAck)) begin
      @(posedge CLK);
      waitCycles++;
      if (waitCycles > timeoutCycles) begin
        reportTimeout(what);
      end
    end
  endtask

  task automatic setAckHold(input logic hold);
    if (hold) begin
      waitRequestsDrained("idle request channel before holding reqAck");
    end
    ackHold <= hold;
  endtask

  task automatic runStep(input stepT s);
    case (s.kind)
      opRead:    readBurst(s);
      opWrite:   writeBurst(s);
      opPushInd: pushIndication(s.data);
      default:   setAckHold(s.data[0]);
    endcase
  endtask

  task automatic checkRequests();
    waitRequestsDrained("all request words on reqWord");
    checkValue("request count", 32'(reqSeen.size()), 32'(reqExpected.size()));
    foreach (reqExpected[i]) begin
      if (i < reqSeen.size()) begin
        checkValue("reqWord", reqSeen[i], reqExpected[i]);
      end
    end
  endtask

  // User side of the request channel
  initial begin
    reqAck = 1'b0;
    forever begin
      @(posedge CLK);
      if (reqReq && !reqAck && !ackHold) begin
        reqSeen.push_back(reqWord);
        reqAck <= 1'b1;
      end else if (!reqReq && reqAck) begin
        reqAck <= 1'b0;
      end
    end
  end

  initial begin
    RST_N   = 1'b0;
    arAddr  = '0;
    arLen   = '0;
    arId    = '0;
    arValid = 1'b0;
    rReady  = 1'b0;
    awAddr  = '0;
    awLen   = '0;
    awId    = '0;
    awValid = 1'b0;
    wData   = '0;
    wValid  = 1'b0;
    bReady  = 1'b0;
    indWord = '0;
    indReq  = 1'b0;
    buildTable();
    repeat (2) @(posedge CLK);
    RST_N <= 1'b1;
    @(posedge CLK);
    checkValue("arReady", 32'(arReady), 32'd1);
    checkValue("awReady", 32'(awReady), 32'd1);
    checkValue("wReady", 32'(wReady), 32'd1);
    checkValue("rValid", 32'(rValid), 32'd0);
    checkValue("bValid", 32'(bValid), 32'd0);
    checkValue("interrupt", 32'(interrupt), 32'd0);
    checkValue("reqReq", 32'(reqReq), 32'd0);
    checkValue("indAck", 32'(indAck), 32'd0);
    foreach (steps[i]) begin
      if (!timedOut) begin
        runStep(steps[i]);
        @(posedge CLK);
        checkValue("interrupt", 32'(interrupt), 32'(steps[i].irq));
      end
    end
    if (!timedOut) begin
      checkRequests();
    end
    $display("Summary: %0d checks, %0d errors, %0d timeouts",
             checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verilog/beatIf.sv
`timescale 1ns/1ps

// One decoded word beat of a burst
interface beatIf #(
  parameter int idWidth = 6
);
  import portalPkg::*;

  logic                   valid;
  logic                   ready;
  logic [offsetWidth-1:0] offset;
  logic [idWidth-1:0]     id;
  logic                   last;
  logic                   isControl;  // Page field all zero
  portalSelT              portal;

  modport source (
    output valid, offset, id, last, isControl, portal,
    input  ready
  );
  modport sink (
    input  valid, offset, id, last, isControl, portal,
    output ready
  );

endinterface

// File: verilog/burstSplitter.sv
`timescale 1ns/1ps

module burstSplitter #(
  parameter int idWidth = 6
) (
  input  logic                           CLK,
  input  logic                           RST_N,
  input  logic [portalPkg::addrWidth-1:0] addr,
  input  logic [portalPkg::lenWidth-1:0]  len,
  input  logic [idWidth-1:0]              id,
  input  logic                           valid,
  output logic                           ready,
  beatIf.source                          beat
);
  import portalPkg::*;

  localparam int burstWidth = portalBit + 1 + lenWidth + idWidth;

  logic [burstWidth-1:0]  burstIn;
  logic [burstWidth-1:0]  burstOut;
  logic                   burstValid;
  logic [portalBit:0]     burstAddr;
  logic [lenWidth-1:0]    burstLen;
  logic [idWidth-1:0]     burstId;
  logic [lenWidth-1:0]    beatCount;
  logic [offsetWidth-1:0] runOffset;
  logic                   beatMove;

  assign burstIn = {addr[portalBit:0], len, id};

  syncFifo #(.width(burstWidth), .depth(1)) addrFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .push     (valid && ready),
    .pushData (burstIn),
    .pop      (beatMove && beat.last),  // Burst done
    .popData  (burstOut),
    .notFull  (ready),
    .notEmpty (burstValid)
  );

  assign {burstAddr, burstLen, burstId} = burstOut;

  assign beat.valid     = burstValid;
  assign beat.offset    = (beatCount == '0) ? burstAddr[offsetWidth-1:0] : runOffset;
  assign beat.id        = burstId;
  assign beat.last      = beatCount == burstLen;
  assign beat.isControl = burstAddr[pageMsb:pageLsb] == '0;
  assign beat.portal    = portalSelT'(burstAddr[portalBit]);
  assign beatMove       = beat.valid && beat.ready;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      beatCount <= '0;
    end else if (beatMove) begin
      beatCount <= beat.last ? '0 : beatCount + 1'b1;
    end
  end

  // Wraps inside the page window
  always_ff @(posedge CLK) begin
    if (beatMove) begin
      runOffset <= beat.offset + offsetWidth'(beatStride);
    end
  end

  assert property (@(posedge CLK) disable iff (!RST_N) burstValid |-> beatCount <= burstLen)
    else $error("burstSplitter beat count passed burst length");

endmodule

// File: verilog/portalBridge.sv
`timescale 1ns/1ps

module portalBridge #(
  parameter int idWidth    = 6,
  parameter int queueDepth = 4
) (
  input  logic                           CLK,
  input  logic                           RST_N,
  input  logic [portalPkg::addrWidth-1:0] arAddr,
  input  logic [portalPkg::lenWidth-1:0]  arLen,
  input  logic [idWidth-1:0]              arId,
  input  logic                           arValid,
  output logic                           arReady,
  output logic [portalPkg::dataWidth-1:0] rData,
  output logic [idWidth-1:0]              rId,
  output logic                           rValid,
  input  logic                           rReady,
  input  logic [portalPkg::addrWidth-1:0] awAddr,
  input  logic [portalPkg::lenWidth-1:0]  awLen,
  input  logic [idWidth-1:0]              awId,
  input  logic                           awValid,
  output logic                           awReady,
  input  logic [portalPkg::dataWidth-1:0] wData,
  input  logic                           wValid,
  output logic                           wReady,
  output logic [idWidth-1:0]              bId,
  output logic                           bValid,
  input  logic                           bReady,
  output logic                           interrupt,
  output logic [portalPkg::dataWidth-1:0] reqWord,
  output logic                           reqReq,
  input  logic                           reqAck,
  input  logic [portalPkg::dataWidth-1:0] indWord,
  input  logic                           indReq,
  output logic                           indAck
);

  beatIf #(.idWidth(idWidth)) readBeat ();
  beatIf #(.idWidth(idWidth)) writeBeat ();
  portalQueueIf queueLink ();

  burstSplitter #(.idWidth(idWidth)) readSplitter (
    .CLK(CLK), .RST_N(RST_N),
    .addr(arAddr), .len(arLen), .id(arId), .valid(arValid), .ready(arReady),
    .beat(readBeat)
  );

  burstSplitter #(.idWidth(idWidth)) writeSplitter (
    .CLK(CLK), .RST_N(RST_N),
    .addr(awAddr), .len(awLen), .id(awId), .valid(awValid), .ready(awReady),
    .beat(writeBeat)
  );

  portalReadEngine #(.idWidth(idWidth)) readEngine (
    .CLK(CLK), .RST_N(RST_N), .beat(readBeat), .queue(queueLink),
    .rData(rData), .rId(rId), .rValid(rValid), .rReady(rReady)
  );

  portalWriteEngine #(.idWidth(idWidth)) writeEngine (
    .CLK(CLK), .RST_N(RST_N), .beat(writeBeat), .queue(queueLink),
    .wData(wData), .wValid(wValid), .wReady(wReady),
    .bId(bId), .bValid(bValid), .bReady(bReady), .interrupt(interrupt)
  );

  portalQueues #(.queueDepth(queueDepth)) queues (
    .CLK(CLK), .RST_N(RST_N), .queue(queueLink),
    .reqWord(reqWord), .reqReq(reqReq), .reqAck(reqAck),
    .indWord(indWord), .indReq(indReq), .indAck(indAck)
  );

endmodule

// File: verilog/portalPkg.sv
package portalPkg;

  localparam int dataWidth   = 32;
  localparam int addrWidth   = 32;
  localparam int lenWidth    = 4;  // Beats = len + 1
  localparam int offsetWidth = 5;
  localparam int pageLsb     = 5;
  localparam int pageMsb     = 11;
  localparam int portalBit   = 12;
  localparam int beatStride  = 4;

  // Control page register map
  typedef enum logic [4:0] {
    ctrlIntStatus   = 5'd0,
    ctrlIntEnable   = 5'd4,
    ctrlNumTiles    = 5'd8,
    ctrlQueueStatus = 5'd12,
    ctrlPortalId    = 5'd16,
    ctrlNumPortals  = 5'd20
  } ctrlRegT;

  typedef enum logic {
    indicationPortal = 1'b0,
    requestPortal    = 1'b1
  } portalSelT;

  typedef enum logic [1:0] {hsIdle, hsReq, hsRelease} hsStateT;

  localparam logic [31:0] numTiles           = 32'd1;
  localparam logic [31:0] numPortals         = 32'd2;
  localparam logic [31:0] indicationPortalId = 32'd5;
  localparam logic [31:0] requestPortalId    = 32'd6;
  localparam logic [31:0] ctrlDefault        = 32'h005A05A0;

endpackage

// File: verilog/portalQueueIf.sv
`timescale 1ns/1ps

interface portalQueueIf;
  import portalPkg::*;

  logic                 reqPush;
  logic [dataWidth-1:0] reqWord;
  logic                 reqNotFull;
  logic                 indPop;
  logic [dataWidth-1:0] indWord;  // Head of indication queue
  logic                 indNotEmpty;

  modport writeSide (
    output reqPush, reqWord,
    input  reqNotFull, indNotEmpty
  );
  modport readSide (
    output indPop,
    input  indWord, indNotEmpty, reqNotFull
  );
  modport queueSide (
    input  reqPush, reqWord, indPop,
    output reqNotFull, indWord, indNotEmpty
  );

endinterface

// File: verilog/portalQueues.sv
`timescale 1ns/1ps

module portalQueues #(
  parameter int queueDepth = 4
) (
  input  logic                           CLK,
  input  logic                           RST_N,
  portalQueueIf.queueSide                queue,
  output logic [portalPkg::dataWidth-1:0] reqWord,
  output logic                           reqReq,
  input  logic                           reqAck,
  input  logic [portalPkg::dataWidth-1:0] indWord,
  input  logic                           indReq,
  output logic                           indAck
);
  import portalPkg::*;

  hsStateT              reqState;
  hsStateT              indState;
  logic [dataWidth-1:0] reqHead;
  logic                 reqPending;
  logic                 reqTake;
  logic                 indNotFull;
  logic                 indStore;

  syncFifo #(.width(dataWidth), .depth(queueDepth)) reqFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .push     (queue.reqPush),
    .pushData (queue.reqWord),
    .pop      (reqTake),
    .popData  (reqHead),
    .notFull  (queue.reqNotFull),
    .notEmpty (reqPending)
  );

  syncFifo #(.width(dataWidth), .depth(queueDepth)) indFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .push     (indStore),
    .pushData (indWord),
    .pop      (queue.indPop),
    .popData  (queue.indWord),
    .notFull  (indNotFull),
    .notEmpty (queue.indNotEmpty)
  );

  // Request sender
  assign reqTake = reqState == hsIdle && reqPending;
  assign reqReq  = reqState == hsReq;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      reqState <= hsIdle;
    end else begin
      case (reqState)
        hsIdle:    if (reqPending) reqState <= hsReq;
        hsReq:     if (reqAck) reqState <= hsRelease;
        hsRelease: if (!reqAck) reqState <= hsIdle;  // Ack low before next word
        default:   reqState <= hsIdle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (reqTake) begin
      reqWord <= reqHead;
    end
  end

  // Indication receiver, ack rises with the store
  assign indStore = indState == hsIdle && indReq && indNotFull;
  assign indAck   = indState == hsReq;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      indState <= hsIdle;
    end else begin
      case (indState)
        hsIdle:  if (indStore) indState <= hsReq;
        hsReq:   if (!indReq) indState <= hsIdle;
        default: indState <= hsIdle;
      endcase
    end
  end

  assert property (@(posedge CLK) disable iff (!RST_N) reqReq && !reqAck |=> reqReq)
    else $error("reqReq dropped before reqAck");

endmodule

// File: verilog/portalReadEngine.sv
`timescale 1ns/1ps

module portalReadEngine #(
  parameter int idWidth = 6
) (
  input  logic                           CLK,
  input  logic                           RST_N,
  beatIf.sink                            beat,
  portalQueueIf.readSide                 queue,
  output logic [portalPkg::dataWidth-1:0] rData,
  output logic [idWidth-1:0]              rId,
  output logic                           rValid,
  input  logic                           rReady
);
  import portalPkg::*;

  logic [dataWidth-1:0]         ctrlValue;
  logic [dataWidth-1:0]         dataValue;
  logic [dataWidth+idWidth-1:0] respIn;
  logic [dataWidth+idWidth-1:0] respOut;
  logic                         respNotFull;
  logic                         needPop;
  logic                         beatFire;

  // Indication data at offset 0 dequeues a word
  assign needPop = !beat.isControl && beat.portal == indicationPortal && beat.offset == '0;

  assign beat.ready   = respNotFull && (!needPop || queue.indNotEmpty);
  assign beatFire     = beat.valid && beat.ready;
  assign queue.indPop = beatFire && needPop;

  always_comb begin
    case (ctrlRegT'(beat.offset))
      ctrlIntStatus,
      ctrlQueueStatus: ctrlValue = dataWidth'(beat.portal == indicationPortal && queue.indNotEmpty);
      ctrlNumTiles:    ctrlValue = numTiles;
      ctrlPortalId:    ctrlValue = (beat.portal == requestPortal) ? requestPortalId
                                                                  : indicationPortalId;
      ctrlNumPortals:  ctrlValue = numPortals;
      default:         ctrlValue = ctrlDefault;
    endcase
  end

  always_comb begin
    if (needPop) begin
      dataValue = queue.indWord;
    end else if (beat.portal == requestPortal && beat.offset == offsetWidth'(4)) begin
      dataValue = dataWidth'(queue.reqNotFull);  // Request space probe
    end else begin
      dataValue = '0;
    end
  end

  assign respIn = {beat.isControl ? ctrlValue : dataValue, beat.id};

  syncFifo #(.width(dataWidth + idWidth), .depth(2)) respFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .push     (beatFire),
    .pushData (respIn),
    .pop      (rValid && rReady),
    .popData  (respOut),
    .notFull  (respNotFull),
    .notEmpty (rValid)
  );

  assign {rData, rId} = respOut;

endmodule

// File: verilog/portalWriteEngine.sv
`timescale 1ns/1ps

module portalWriteEngine #(
  parameter int idWidth = 6
) (
  input  logic                           CLK,
  input  logic                           RST_N,
  beatIf.sink                            beat,
  portalQueueIf.writeSide                queue,
  input  logic [portalPkg::dataWidth-1:0] wData,
  input  logic                           wValid,
  output logic                           wReady,
  output logic [idWidth-1:0]              bId,
  output logic                           bValid,
  input  logic                           bReady,
  output logic                           interrupt
);
  import portalPkg::*;

  localparam int descWidth = offsetWidth + idWidth + 3;

  logic [descWidth-1:0]   descIn;
  logic [descWidth-1:0]   descOut;
  logic                   descValid;
  logic [offsetWidth-1:0] curOffset;
  logic [idWidth-1:0]     curId;
  logic                   curLast;
  logic                   curControl;
  portalSelT              curPortal;
  logic [dataWidth-1:0]   word;
  logic                   wordValid;
  logic                   respNotFull;
  logic                   toRequest;
  logic                   consume;
  logic                   intEnable;

  assign descIn = {beat.offset, beat.id, beat.last, beat.isControl, beat.portal};

  // Beats wait here for their data words
  syncFifo #(.width(descWidth), .depth(2)) beatFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .push     (beat.valid && beat.ready),
    .pushData (descIn),
    .pop      (consume),
    .popData  (descOut),
    .notFull  (beat.ready),
    .notEmpty (descValid)
  );

  assign {curOffset, curId, curLast, curControl} = descOut[descWidth-1:1];
  assign curPortal = portalSelT'(descOut[0]);

  syncFifo #(.width(dataWidth), .depth(2)) dataFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .push     (wValid && wReady),
    .pushData (wData),
    .pop      (consume),
    .popData  (word),
    .notFull  (wReady),
    .notEmpty (wordValid)
  );

  assign toRequest = !curControl && curPortal == requestPortal;
  assign consume   = descValid && wordValid && (!curLast || respNotFull) &&
                     (!toRequest || queue.reqNotFull);

  assign queue.reqPush = consume && toRequest;
  assign queue.reqWord = word;

  syncFifo #(.width(idWidth), .depth(1)) respFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .push     (consume && curLast),  // One response per burst
    .pushData (curId),
    .pop      (bValid && bReady),
    .popData  (bId),
    .notFull  (respNotFull),
    .notEmpty (bValid)
  );

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      intEnable <= 1'b0;
    end else if (consume && curControl && curOffset == ctrlIntEnable) begin
      intEnable <= word[0];
    end
  end

  assign interrupt = intEnable && queue.indNotEmpty;

  assert property (@(posedge CLK) disable iff (!RST_N)
                   bValid && !bReady |=> bValid && $stable(bId))
    else $error("write response dropped before bReady");

endmodule

// File: verilog/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
  parameter int width = 32,
  parameter int depth = 2
) (
  input  logic             CLK,
  input  logic             RST_N,
  input  logic             push,
  input  logic [width-1:0] pushData,
  input  logic             pop,
  output logic [width-1:0] popData,
  output logic             notFull,
  output logic             notEmpty
);
  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntWidth = $clog2(depth + 1);

  logic [width-1:0]    mem [depth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [cntWidth-1:0] count;

  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
    return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign popData  = mem[rdPtr];
  assign notFull  = count != cntWidth'(depth);
  assign notEmpty = count != '0;

  assert property (@(posedge CLK) disable iff (!RST_N) push |-> notFull)
    else $error("syncFifo push while full");
  assert property (@(posedge CLK) disable iff (!RST_N) pop |-> notEmpty)
    else $error("syncFifo pop while empty");

endmodule
